/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = SpiBlockTb
FILELIST = all.f
BUILD    = obj_dir
SIM      = $(BUILD)/V$(TOP)
SRCS     = $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf $(BUILD)

/* all.f */
common/spiBusPkg.sv
common/spiFlashPkg.sv
spiCsr/SpiCsr.sv
spiFlash/SpiFlashUnit.sv
spiSlave/SpiSlavePort.sv
rtl/SpiBusBridge.sv
rtl/SpiBlock.sv
verification/SpiBlockTb.sv

/* common/spiBusPkg.sv */
// ------------------
// Register bus package
// Bus widths, block address map and CSR offsets
// ------------------
package spiBusPkg;

	// ------------------
	// Bus geometry
	// ------------------

	// Data and address width
	localparam int BUS_WIDTH = 32;

	// Block select field in the top address bits
	localparam int BLOCK_ADRS_WIDTH = 8;
	localparam logic [BLOCK_ADRS_WIDTH-1:0] BLOCK_ADRS_MAP = 8'h03;

	// Register offset in the low address bits
	localparam int CSR_OFFSET_WIDTH = 8;

	// ------------------
	// Register map
	// ------------------

	// Flash select, busy flags of all units from bit 8
	localparam logic [CSR_OFFSET_WIDTH-1:0] REG_SEL = 8'h00;

	// Per-unit register windows
	localparam logic [CSR_OFFSET_WIDTH-1:0] REG_UNIT_BASE = 8'h10;
	localparam logic [CSR_OFFSET_WIDTH-1:0] REG_UNIT_STRIDE = 8'h10;

	// Offsets inside one unit window
	// Bit 0 enable, bit 1 chip select asserted
	localparam logic [CSR_OFFSET_WIDTH-1:0] REG_CTRL = 8'h00;
	// Half-period divider
	localparam logic [CSR_OFFSET_WIDTH-1:0] REG_DIV = 8'h04;
	// Write starts a transfer
	localparam logic [CSR_OFFSET_WIDTH-1:0] REG_TX = 8'h08;
	// Received byte, busy in bit 8
	localparam logic [CSR_OFFSET_WIDTH-1:0] REG_RX = 8'h0C;

endpackage

/* common/spiFlashPkg.sv */
// ------------------
// Flash side package
// Flash count, divider width and CPU frame codes
// ------------------
package spiFlashPkg;

	// Number of attached flash devices
	localparam int SFM_NUM = 2;

	// Width of the flash select field
	localparam int SFM_SEL_WIDTH = 1;

	// Clock divider width per unit
	localparam int DIV_WIDTH = 8;

	// ------------------
	// CPU frame format
	// ------------------

	// Command byte values
	localparam logic [7:0] CMD_WRITE = 8'h02;
	localparam logic [7:0] CMD_READ = 8'h03;

	// Address byte, lands on bus bits 31:24
	localparam int FRAME_ADRS_WIDTH = 8;

endpackage

/* rtl/SpiBlock.sv */
// ------------------
// SPI subsystem top
// CPU slave port, bus bridge, register file
// and one master engine per flash device
// ------------------
`timescale 1ns/1ps

module SpiBlock
	import spiBusPkg::*, spiFlashPkg::*;
(
	input  logic                    sClk,
	input  logic                    rstN,
	// Register bus slave
	input  logic [BUS_WIDTH-1:0]    busAdrs,
	input  logic [BUS_WIDTH-1:0]    busWrData,
	input  logic                    busWrEn,
	input  logic                    busRdEn,
	output logic [BUS_WIDTH-1:0]    busRdData,
	// Register bus master
	output logic [BUS_WIDTH-1:0]    mstAdrs,
	output logic [BUS_WIDTH-1:0]    mstWrData,
	output logic                    mstWrEn,
	output logic                    mstRdEn,
	input  logic [BUS_WIDTH-1:0]    mstRdData,
	// CPU SPI pins
	input  logic                    spiSck,
	input  logic                    spiMosi,
	input  logic                    spiCs,
	input  logic                    spiThru,
	output logic                    spiMiso,
	// Flash pins
	output logic [SFM_NUM-1:0]      sfmSck,
	output logic [SFM_NUM-1:0]      sfmMosi,
	output logic [SFM_NUM-1:0]      sfmCs,
	input  logic [SFM_NUM-1:0]      sfmMiso
);

	// Register file to flash units
	logic [SFM_NUM-1:0]                 ctrlEn;
	logic [SFM_NUM-1:0]                 csActive;
	logic [SFM_NUM-1:0][DIV_WIDTH-1:0]  div;
	logic [SFM_NUM-1:0][7:0]            txData;
	logic [SFM_NUM-1:0]                 txStart;
	logic [SFM_NUM-1:0][7:0]            rxData;
	logic [SFM_NUM-1:0]                 busy;
	logic [SFM_SEL_WIDTH-1:0]           flashSel;
	// Unit pins before the thru mux
	logic [SFM_NUM-1:0]                 sfuSck;
	logic [SFM_NUM-1:0]                 sfuMosi;
	logic [SFM_NUM-1:0]                 sfuCs;
	logic [SFM_NUM-1:0]                 sfuMiso;
	// Decoded frames
	logic [FRAME_ADRS_WIDTH-1:0]        decAdrs;
	logic [BUS_WIDTH-1:0]               decWrData;
	logic                               decWrEn;
	logic                               decRdEn;
	logic [BUS_WIDTH-1:0]               rdWord;

	SpiCsr SpiCsr_inst (
		.sClk(sClk),            .rstN(rstN),
		.busAdrs(busAdrs),      .busWrData(busWrData),
		.busWrEn(busWrEn),      .busRdEn(busRdEn),      .busRdData(busRdData),
		.ctrlEn(ctrlEn),        .csActive(csActive),    .div(div),
		.txData(txData),        .txStart(txStart),
		.rxData(rxData),        .busy(busy),            .flashSel(flashSel)
	);

	SpiBusBridge SpiBusBridge_inst (
		.sClk(sClk),            .rstN(rstN),
		.decAdrs(decAdrs),      .decWrData(decWrData),
		.decWrEn(decWrEn),      .decRdEn(decRdEn),      .rdWord(rdWord),
		.mstAdrs(mstAdrs),      .mstWrData(mstWrData),
		.mstWrEn(mstWrEn),      .mstRdEn(mstRdEn),      .mstRdData(mstRdData)
	);

	SpiSlavePort SpiSlavePort_inst (
		.sClk(sClk),            .rstN(rstN),
		.spiSck(spiSck),        .spiMosi(spiMosi),      .spiCs(spiCs),
		.spiThru(spiThru),      .spiMiso(spiMiso),
		.sfuSck(sfuSck),        .sfuMosi(sfuMosi),      .sfuCs(sfuCs),
		.sfuMiso(sfuMiso),
		.sfmSck(sfmSck),        .sfmMosi(sfmMosi),      .sfmCs(sfmCs),
		.sfmMiso(sfmMiso),      .flashSel(flashSel),
		.decAdrs(decAdrs),      .decWrData(decWrData),
		.decWrEn(decWrEn),      .decRdEn(decRdEn),      .rdWord(rdWord)
	);

	// One master engine per flash device
	for (genvar i = 0; i < SFM_NUM; i++)
	begin : genUnit
		SpiFlashUnit SpiFlashUnit_inst (
			.sClk(sClk),            .rstN(rstN),
			.ctrlEn(ctrlEn[i]),     .csActive(csActive[i]), .div(div[i]),
			.txData(txData[i]),     .txStart(txStart[i]),
			.rxData(rxData[i]),     .busy(busy[i]),
			.sfuSck(sfuSck[i]),     .sfuMosi(sfuMosi[i]),   .sfuCs(sfuCs[i]),
			.sfuMiso(sfuMiso[i])
		);
	end

endmodule

/* rtl/SpiBusBridge.sv */
// ------------------
// Frame to bus bridge
// Issues bus-master cycles, returns read data
// ------------------
`timescale 1ns/1ps

module SpiBusBridge
	import spiBusPkg::*, spiFlashPkg::*;
(
	input  logic                            sClk,
	input  logic                            rstN,
	input  logic [FRAME_ADRS_WIDTH-1:0]     decAdrs,
	input  logic [BUS_WIDTH-1:0]            decWrData,
	input  logic                            decWrEn,
	input  logic                            decRdEn,
	output logic [BUS_WIDTH-1:0]            rdWord,
	output logic [BUS_WIDTH-1:0]            mstAdrs,
	output logic [BUS_WIDTH-1:0]            mstWrData,
	output logic                            mstWrEn,
	output logic                            mstRdEn,
	input  logic [BUS_WIDTH-1:0]            mstRdData
);

	// Fixed latency slot for mstRdData
	logic                   rdAck;
	logic [BUS_WIDTH-1:0]   rdHold;

	always_ff @(posedge sClk or negedge rstN)
	begin
		if (!rstN)
		begin
			mstWrEn <= 1'b0;
			mstRdEn <= 1'b0;
			rdAck <= 1'b0;
		end
		else
		begin
			mstWrEn <= decWrEn;
			mstRdEn <= decRdEn;
			rdAck <= mstRdEn;
		end
	end

	always_ff @(posedge sClk)
	begin
		// Frame address on the top byte
		if (decWrEn || decRdEn)
			mstAdrs <= {decAdrs, {(BUS_WIDTH-FRAME_ADRS_WIDTH){1'b0}}};
		if (decWrEn)
			mstWrData <= decWrData;
		if (rdAck)
			rdHold <= mstRdData;
	end

	// Live on the capture cycle, held after
	assign rdWord = rdAck ? mstRdData : rdHold;

endmodule

/* spiCsr/SpiCsr.sv */
// ------------------
// SPI register file
// Flash select plus per-unit control, divider,
// transmit and receive registers
// ------------------
`timescale 1ns/1ps

module SpiCsr
	import spiBusPkg::*, spiFlashPkg::*;
(
	input  logic                                sClk,
	input  logic                                rstN,
	input  logic [BUS_WIDTH-1:0]                busAdrs,
	input  logic [BUS_WIDTH-1:0]                busWrData,
	input  logic                                busWrEn,
	input  logic                                busRdEn,
	output logic [BUS_WIDTH-1:0]                busRdData,
	output logic [SFM_NUM-1:0]                  ctrlEn,
	output logic [SFM_NUM-1:0]                  csActive,
	output logic [SFM_NUM-1:0][DIV_WIDTH-1:0]   div,
	output logic [SFM_NUM-1:0][7:0]             txData,
	output logic [SFM_NUM-1:0]                  txStart,
	input  logic [SFM_NUM-1:0][7:0]             rxData,
	input  logic [SFM_NUM-1:0]                  busy,
	output logic [SFM_SEL_WIDTH-1:0]            flashSel
);

	logic                           blockHit;
	logic                           wrHit;
	logic [CSR_OFFSET_WIDTH-1:0]    offset;
	logic [BUS_WIDTH-1:0]           rdWord;

	// Offset of one register inside a unit window
	function automatic logic [CSR_OFFSET_WIDTH-1:0] unitOfs(
		input int                           unit,
		input logic [CSR_OFFSET_WIDTH-1:0]  regOfs
	);
		unitOfs = REG_UNIT_BASE + CSR_OFFSET_WIDTH'(unit) * REG_UNIT_STRIDE + regOfs;
	endfunction

	// Block field decode
	assign blockHit = busAdrs[BUS_WIDTH-1 -: BLOCK_ADRS_WIDTH] == BLOCK_ADRS_MAP;
	assign offset = busAdrs[CSR_OFFSET_WIDTH-1:0];
	assign wrHit = busWrEn && blockHit;

	// ------------------
	// Write side
	// ------------------
	always_ff @(posedge sClk or negedge rstN)
	begin
		if (!rstN)
		begin
			flashSel <= '0;
			ctrlEn <= '0;
			csActive <= '0;
			div <= '0;
			txData <= '0;
			txStart <= '0;
		end
		else
		begin
			// Start strobe lasts one cycle
			txStart <= '0;
			if (wrHit && offset == REG_SEL)
				flashSel <= busWrData[SFM_SEL_WIDTH-1:0];
			for (int i = 0; i < SFM_NUM; i++)
			begin
				if (wrHit && offset == unitOfs(i, REG_CTRL))
				begin
					ctrlEn[i] <= busWrData[0];
					csActive[i] <= busWrData[1];
				end
				if (wrHit && offset == unitOfs(i, REG_DIV))
					div[i] <= busWrData[DIV_WIDTH-1:0];
				// Unit ignores the strobe while busy
				if (wrHit && offset == unitOfs(i, REG_TX))
				begin
					txData[i] <= busWrData[7:0];
					txStart[i] <= 1'b1;
				end
			end
		end
	end

	// ------------------
	// Read side
	// ------------------
	always_comb
	begin
		rdWord = '0;
		if (offset == REG_SEL)
		begin
			rdWord[SFM_SEL_WIDTH-1:0] = flashSel;
			// Busy flags of all units
			rdWord[8 +: SFM_NUM] = busy;
		end
		for (int i = 0; i < SFM_NUM; i++)
		begin
			if (offset == unitOfs(i, REG_CTRL))
				rdWord[1:0] = {csActive[i], ctrlEn[i]};
			if (offset == unitOfs(i, REG_DIV))
				rdWord[DIV_WIDTH-1:0] = div[i];
			if (offset == unitOfs(i, REG_TX))
				rdWord[7:0] = txData[i];
			// Live receive byte and busy
			if (offset == unitOfs(i, REG_RX))
				rdWord[8:0] = {busy[i], rxData[i]};
		end
	end

	// One cycle read latency, held until next read
	always_ff @(posedge sClk or negedge rstN)
	begin
		if (!rstN)
			busRdData <= '0;
		else if (busRdEn)
			busRdData <= blockHit ? rdWord : '0;
	end

endmodule

/* spiFlash/SpiFlashUnit.sv */
// ------------------
// Flash SPI master engine
// One byte per transfer, mode 0, MSB first
// ------------------
`timescale 1ns/1ps

module SpiFlashUnit
	import spiFlashPkg::*;
(
	input  logic                    sClk,
	input  logic                    rstN,
	input  logic                    ctrlEn,
	input  logic                    csActive,
	input  logic [DIV_WIDTH-1:0]    div,
	input  logic [7:0]              txData,
	input  logic                    txStart,
	output logic [7:0]              rxData,
	output logic                    busy,
	output logic                    sfuSck,
	output logic                    sfuMosi,
	output logic                    sfuCs,
	input  logic                    sfuMiso
);

	logic [DIV_WIDTH-1:0]   divCnt;
	// Sixteen sck half periods per byte
	logic [3:0]             edgeCnt;
	logic [7:0]             txShift;
	logic [7:0]             rxShift;
	logic                   halfDone;
	logic                   start;

	// Accepted only when idle and enabled
	assign start = txStart && !busy && ctrlEn;
	// End of one half period of sck
	assign halfDone = busy && ctrlEn && divCnt == div;

	// ------------------
	// Sequencing
	// ------------------
	always_ff @(posedge sClk or negedge rstN)
	begin
		if (!rstN)
		begin
			busy <= 1'b0;
			divCnt <= '0;
			edgeCnt <= '0;
			sfuSck <= 1'b0;
			rxData <= '0;
		end
		else if (start)
		begin
			busy <= 1'b1;
			divCnt <= '0;
			edgeCnt <= '0;
		end
		else if (halfDone)
		begin
			divCnt <= '0;
			sfuSck <= ~sfuSck;
			edgeCnt <= edgeCnt + 1'b1;
			// Last falling edge, byte complete
			if (edgeCnt == 4'd15)
			begin
				busy <= 1'b0;
				rxData <= rxShift;
			end
		end
		else if (busy && ctrlEn)
			divCnt <= divCnt + 1'b1;
	end

	// ------------------
	// Shift registers
	// ------------------
	always_ff @(posedge sClk)
	begin
		if (start)
			txShift <= txData;
		else if (halfDone)
		begin
			// Falling edge shifts next bit out
			if (sfuSck)
				txShift <= {txShift[6:0], 1'b0};
			// Rising edge samples miso
			else
				rxShift <= {rxShift[6:0], sfuMiso};
		end
	end

	assign sfuMosi = txShift[7];
	// Held low across bytes while software keeps it active
	assign sfuCs = ~(csActive & ctrlEn);

endmodule

/* spiSlave/SpiSlavePort.sv */
// ------------------
// CPU SPI slave port
// Frame decoder toward the bus bridge
// and thru mux from CPU pins to the flash pins
// ------------------
`timescale 1ns/1ps

module SpiSlavePort
	import spiBusPkg::*, spiFlashPkg::*;
(
	input  logic                            sClk,
	input  logic                            rstN,
	input  logic                            spiSck,
	input  logic                            spiMosi,
	input  logic                            spiCs,
	input  logic                            spiThru,
	output logic                            spiMiso,
	input  logic [SFM_NUM-1:0]              sfuSck,
	input  logic [SFM_NUM-1:0]              sfuMosi,
	input  logic [SFM_NUM-1:0]              sfuCs,
	output logic [SFM_NUM-1:0]              sfuMiso,
	output logic [SFM_NUM-1:0]              sfmSck,
	output logic [SFM_NUM-1:0]              sfmMosi,
	output logic [SFM_NUM-1:0]              sfmCs,
	input  logic [SFM_NUM-1:0]              sfmMiso,
	input  logic [SFM_SEL_WIDTH-1:0]        flashSel,
	output logic [FRAME_ADRS_WIDTH-1:0]     decAdrs,
	output logic [BUS_WIDTH-1:0]            decWrData,
	output logic                            decWrEn,
	output logic                            decRdEn,
	input  logic [BUS_WIDTH-1:0]            rdWord
);

	// Two sync flops plus one for edge detect
	logic [2:0]             sckSync;
	logic [1:0]             mosiSync;
	logic [1:0]             csSync;
	logic [1:0]             thruSync;
	logic                   sckRise;
	logic                   sckFall;
	logic                   frameIdle;
	logic [5:0]             bitCnt;
	logic [7:0]             cmd;
	logic [BUS_WIDTH-1:0]   rxShift;
	logic [BUS_WIDTH-1:0]   txShift;
	// Read answer arrives two cycles after decRdEn
	logic [1:0]             rdDly;

	always_ff @(posedge sClk or negedge rstN)
	begin
		if (!rstN)
		begin
			sckSync <= '0;
			mosiSync <= '0;
			csSync <= '1;
			thruSync <= '0;
		end
		else
		begin
			sckSync <= {sckSync[1:0], spiSck};
			mosiSync <= {mosiSync[0], spiMosi};
			csSync <= {csSync[0], spiCs};
			thruSync <= {thruSync[0], spiThru};
		end
	end

	assign sckRise = sckSync[1] & ~sckSync[2];
	assign sckFall = ~sckSync[1] & sckSync[2];
	// Decoder rests while deselected or in thru mode
	assign frameIdle = csSync[1] | thruSync[1];

	// ------------------
	// Frame decoder
	// ------------------
	always_ff @(posedge sClk or negedge rstN)
	begin
		if (!rstN)
		begin
			bitCnt <= '0;
			cmd <= '0;
			decWrEn <= 1'b0;
			decRdEn <= 1'b0;
			rdDly <= '0;
		end
		else
		begin
			decWrEn <= 1'b0;
			decRdEn <= 1'b0;
			rdDly <= {rdDly[0], decRdEn};
			if (frameIdle)
				bitCnt <= '0;
			else if (sckRise)
			begin
				if (bitCnt != '1)
					bitCnt <= bitCnt + 1'b1;
				// Command byte done
				if (bitCnt == 6'd7)
					cmd <= {rxShift[6:0], mosiSync[1]};
				// Address byte done, read starts here
				if (bitCnt == 6'd15 && cmd == CMD_READ)
					decRdEn <= 1'b1;
				// Last write data bit
				if (bitCnt == 6'd47 && cmd == CMD_WRITE)
					decWrEn <= 1'b1;
			end
		end
	end

	always_ff @(posedge sClk)
	begin
		if (sckRise && !frameIdle)
		begin
			rxShift <= {rxShift[BUS_WIDTH-2:0], mosiSync[1]};
			if (bitCnt == 6'd15)
				decAdrs <= {rxShift[FRAME_ADRS_WIDTH-2:0], mosiSync[1]};
			if (bitCnt == 6'd47 && cmd == CMD_WRITE)
				decWrData <= {rxShift[BUS_WIDTH-2:0], mosiSync[1]};
		end
		// MSB sits on miso before the first data rising edge
		if (rdDly[1])
			txShift <= rdWord;
		else if (sckFall && !frameIdle && bitCnt >= 6'd25)
			txShift <= {txShift[BUS_WIDTH-2:0], 1'b0};
	end

	// ------------------
	// Thru mux
	// ------------------
	always_comb
	begin
		for (int i = 0; i < SFM_NUM; i++)
		begin
			if (spiThru && flashSel == SFM_SEL_WIDTH'(i))
			begin
				sfmSck[i] = spiSck;
				sfmMosi[i] = spiMosi;
				sfmCs[i] = spiCs;
			end
			else
			begin
				sfmSck[i] = sfuSck[i];
				sfmMosi[i] = sfuMosi[i];
				sfmCs[i] = sfuCs[i];
			end
		end
	end

	// Units always see their own flash
	assign sfuMiso = sfmMiso;
	assign spiMiso = spiThru ? sfmMiso[flashSel] : txShift[BUS_WIDTH-1];

endmodule

/* verification/SpiBlockTb.sv */
// ------------------
// SPI subsystem testbench
// Random register, flash, CPU frame and thru traffic
// checked against bus, memory and flash models
// ------------------
`timescale 1ns/1ps

module SpiBlockTb
	import spiBusPkg::*, spiFlashPkg::*;
();

	// sClk cycles per half sck period of the CPU
	localparam int HALF_SCK = 8;
	localparam int MAX_DIV = 16;
	localparam int N_REG = 40;
	localparam int N_XFER = 8;
	localparam int N_BUSY = 4;
	localparam int N_FRAME = 8;
	localparam int N_THRU = 4;
	// Worst case lengths in cycles
	localparam int FRAME_CYCLES = 2 * HALF_SCK * 58 + 64;
	localparam int XFER_CYCLES = 16 * MAX_DIV + 80;
	localparam int TIMEOUT = 2 * ((2 * N_FRAME + N_THRU) * FRAME_CYCLES
		+ (N_XFER + N_BUSY) * XFER_CYCLES + N_REG * 40 + 200);

	logic sClk;
	logic rstN;
	logic [BUS_WIDTH-1:0] busAdrs;
	logic [BUS_WIDTH-1:0] busWrData;
	logic busWrEn;
	logic busRdEn;
	logic [BUS_WIDTH-1:0] busRdData;
	logic [BUS_WIDTH-1:0] mstAdrs;
	logic [BUS_WIDTH-1:0] mstWrData;
	logic mstWrEn;
	logic mstRdEn;
	logic [BUS_WIDTH-1:0] mstRdData;
	logic spiSck;
	logic spiMosi;
	logic spiCs;
	logic spiThru;
	logic spiMiso;
	logic [SFM_NUM-1:0] sfmSck;
	logic [SFM_NUM-1:0] sfmMosi;
	logic [SFM_NUM-1:0] sfmCs;
	logic [SFM_NUM-1:0] sfmMiso;

	// Register model
	logic [SFM_SEL_WIDTH-1:0] selM;
	logic [1:0] ctrlM [SFM_NUM];
	logic [7:0] divM [SFM_NUM];
	// Flash models
	logic [7:0] flOut [SFM_NUM] = '{default: 8'hA5};
	logic [7:0] flShift [SFM_NUM] = '{default: 8'h00};
	logic [7:0] flRxLast [SFM_NUM] = '{default: 8'h00};
	int flCnt [SFM_NUM] = '{default: 0};
	int flDone [SFM_NUM] = '{default: 0};
	logic [SFM_NUM-1:0] prevSck = '0;
	// Bus master monitor
	int cycleCnt = 0;
	int wrPulses = 0;
	int rdPulses = 0;
	int wrCycle = 0;
	int lastRiseCycle = 0;
	logic [BUS_WIDTH-1:0] lastWrAdrs;
	logic [BUS_WIDTH-1:0] lastWrData;
	int errors = 0;
	int checks = 0;

	SpiBlock SpiBlock_inst (.*);

	initial
	begin
		sClk = 1'b0;
		forever #50 sClk = ~sClk;
	end

	// ------------------
	// Models and monitors
	// ------------------

	// Cycle count, bus master pulses, memory answer, run limit
	always @(posedge sClk)
	begin
		cycleCnt++;
		if (mstWrEn)
		begin
			wrPulses++;
			wrCycle = cycleCnt;
			lastWrAdrs = mstAdrs;
			lastWrData = mstWrData;
		end
		if (cycleCnt >= TIMEOUT)
		begin
			$display("Run stopped: cycle limit %0d reached before the tests ended", TIMEOUT);
			$display("Some tests failed");
			$finish;
		end
		else if (mstRdEn)
		begin
			rdPulses++;
			#10 mstRdData = memWord(mstAdrs);
		end
	end

	// Flash slaves, mode 0, echo last received byte
	always @(sfmSck or sfmCs)
	begin
		for (int i = 0; i < SFM_NUM; i++)
		begin
			if (sfmCs[i] === 1'b1)
				flCnt[i] = 0;
			else
			begin
				if (sfmSck[i] === 1'b1 && prevSck[i] === 1'b0)
				begin
					flShift[i] = {flShift[i][6:0], sfmMosi[i]};
					flCnt[i]++;
				end
				if (sfmSck[i] === 1'b0 && prevSck[i] === 1'b1 && flCnt[i] == 8)
				begin
					flRxLast[i] = flShift[i];
					flOut[i] = flShift[i];
					flCnt[i] = 0;
					flDone[i]++;
				end
			end
			prevSck[i] = sfmSck[i];
		end
	end

	for (genvar g = 0; g < SFM_NUM; g++)
	begin : genMiso
		assign sfmMiso[g] = flOut[g][3'(7 - flCnt[g])];
	end

	// ------------------
	// Helpers
	// ------------------
	function automatic logic [31:0] memWord(input logic [31:0] a);
		memWord = {a[31:24], ~a[31:24], a[31:24] ^ 8'h5C, a[31:24] + 8'h31} ^ {8'h00, a[23:0]};
	endfunction

	function automatic logic [31:0] csrAdrs(input logic [7:0] ofs);
		csrAdrs = {BLOCK_ADRS_MAP, 16'h0000, ofs};
	endfunction

	function automatic logic [7:0] unitOffset(input int u, input logic [7:0] r);
		unitOffset = REG_UNIT_BASE + 8'(u) * REG_UNIT_STRIDE + r;
	endfunction

	function automatic bit isMapped(input logic [7:0] o);
		isMapped = o == REG_SEL || (o >= REG_UNIT_BASE
			&& o < REG_UNIT_BASE + 8'(SFM_NUM) * REG_UNIT_STRIDE && o[1:0] == 2'b00);
	endfunction

	task automatic logError(input string what, input logic [31:0] got, input logic [31:0] exp);
		$display("[ERROR] %0d ns: %s got %h expected %h", $time, what, got, exp);
		errors++;
	endtask

	task automatic waitCycles(input int n);
		repeat (n) @(posedge sClk);
		#10;
	endtask

	task automatic busWrite(input logic [31:0] a, input logic [31:0] d);
		busAdrs = a;
		busWrData = d;
		busWrEn = 1'b1;
		@(posedge sClk);
		#10;
		busWrEn = 1'b0;
	endtask

	task automatic busRead(input logic [31:0] a, output logic [31:0] d);
		busAdrs = a;
		busRdEn = 1'b1;
		@(posedge sClk);
		#10;
		busRdEn = 1'b0;
		d = busRdData;
	endtask

	// Selected flash follows CPU pins
	task automatic verifyThru();
		checks++;
		if (sfmSck[selM] !== spiSck)
			logError("thru sck", 32'(sfmSck[selM]), 32'(spiSck));
		if (sfmMosi[selM] !== spiMosi)
			logError("thru mosi", 32'(sfmMosi[selM]), 32'(spiMosi));
		if (sfmCs[selM] !== spiCs)
			logError("thru cs", 32'(sfmCs[selM]), 32'(spiCs));
		if (spiMiso !== sfmMiso[selM])
			logError("thru miso", 32'(spiMiso), 32'(sfmMiso[selM]));
		if (sfmCs[~selM] !== 1'b1)
			logError("other flash cs", 32'(sfmCs[~selM]), 32'd1);
	endtask

	// Bit-banged CPU master, mode 0, MSB first
	task automatic cpuFrame(input logic [55:0] outBits, input int nBits,
		input bit thruChk, output logic [55:0] inBits);
		inBits = '0;
		spiCs = 1'b0;
		waitCycles(HALF_SCK);
		for (int b = 0; b < nBits; b++)
		begin
			spiMosi = outBits[55-b];
			#1;
			if (thruChk)
				verifyThru();
			waitCycles(HALF_SCK);
			inBits = {inBits[54:0], spiMiso};
			spiSck = 1'b1;
			lastRiseCycle = cycleCnt;
			#1;
			if (thruChk)
				verifyThru();
			waitCycles(HALF_SCK);
			spiSck = 1'b0;
		end
		waitCycles(HALF_SCK);
		spiCs = 1'b1;
		#1;
		if (thruChk)
			verifyThru();
		waitCycles(HALF_SCK);
	endtask

	task automatic checkRegs();
		logic [31:0] got;
		busRead(csrAdrs(REG_SEL), got);
		checks++;
		if (got !== 32'(selM))
			logError("SEL readback", got, 32'(selM));
		for (int u = 0; u < SFM_NUM; u++)
		begin
			busRead(csrAdrs(unitOffset(u, REG_CTRL)), got);
			if (got !== 32'(ctrlM[u]))
				logError("CTRL readback", got, 32'(ctrlM[u]));
			busRead(csrAdrs(unitOffset(u, REG_DIV)), got);
			if (got !== 32'(divM[u]))
				logError("DIV readback", got, 32'(divM[u]));
		end
	endtask

	// ------------------
	// Tests
	// ------------------
	task automatic exerciseRegisters();
		int u;
		logic [31:0] d;
		logic [31:0] got;
		logic [7:0] ofs;
		logic [7:0] blk;
		for (int k = 0; k < N_REG; k++)
		begin
			u = int'($urandom % SFM_NUM);
			d = $urandom;
			case ($urandom % 5)
				0:
				begin
					busWrite(csrAdrs(REG_SEL), d);
					selM = d[SFM_SEL_WIDTH-1:0];
				end
				1:
				begin
					busWrite(csrAdrs(unitOffset(u, REG_CTRL)), d);
					ctrlM[u] = d[1:0];
				end
				2:
				begin
					busWrite(csrAdrs(unitOffset(u, REG_DIV)), d);
					divM[u] = d[7:0];
				end
				3:
				begin
					// Unmapped offset inside the block
					ofs = 8'($urandom);
					while (isMapped(ofs))
						ofs = 8'($urandom);
					busWrite(csrAdrs(ofs), d);
					busRead(csrAdrs(ofs), got);
					if (got !== 32'h0)
						logError("unmapped read", got, 32'h0);
				end
				default:
				begin
					// Foreign block field, mapped offset
					blk = 8'($urandom);
					if (blk == BLOCK_ADRS_MAP)
						blk = 8'h04;
					ofs = unitOffset(u, 8'(4 * ($urandom % 3)));
					busWrite({blk, 16'h0000, ofs}, d);
					busRead({blk, 16'h0000, ofs}, got);
					if (got !== 32'h0)
						logError("foreign block read", got, 32'h0);
				end
			endcase
			checkRegs();
		end
	endtask

	task automatic flashTransfer(input bit busyWrite);
		int u;
		int cycles;
		int startDone;
		logic [7:0] tx;
		logic [7:0] prevOut;
		logic [7:0] dv;
		logic [31:0] got;
		logic [31:0] selExp;
		u = int'($urandom % SFM_NUM);
		tx = 8'($urandom);
		dv = 8'($urandom % MAX_DIV);
		busWrite(csrAdrs(unitOffset(u, REG_CTRL)), 32'h3);
		busWrite(csrAdrs(unitOffset(u, REG_DIV)), 32'(dv));
		prevOut = flOut[u];
		startDone = flDone[u];
		busWrite(csrAdrs(unitOffset(u, REG_TX)), 32'(tx));
		// Select plus this unit's busy flag
		selExp = 32'(selM) | (32'd1 << (8 + u));
		// One bus access per cycle until busy reads clear
		cycles = 0;
		got = '0;
		do
		begin
			if (busyWrite && cycles == 3)
				busWrite(csrAdrs(unitOffset(u, REG_TX)), 32'(~tx));
			else if (cycles == 1)
			begin
				busRead(csrAdrs(REG_SEL), got);
				if (got !== selExp)
					logError("SEL with busy flag", got, selExp);
			end
			else
				busRead(csrAdrs(unitOffset(u, REG_RX)), got);
			cycles++;
			if (cycles == 3 && got[8] !== 1'b1)
				logError("RX busy flag", 32'(got[8]), 32'd1);
		end
		while (cycles < 3 || got[8] === 1'b1);
		checks++;
		// Busy in every read of the transfer, one clear read on each side
		if (cycles != 16 * (int'(dv) + 1) + 2)
			logError("transfer cycles", 32'(cycles), 32'(16 * (int'(dv) + 1) + 2));
		if (flRxLast[u] !== tx)
			logError("flash received byte", 32'(flRxLast[u]), 32'(tx));
		if (got !== {24'h0, prevOut})
			logError("RX with busy clear", got, {24'h0, prevOut});
		waitCycles(4 * (int'(dv) + 1));
		if (flDone[u] != startDone + 1)
			logError("bytes exchanged", 32'(flDone[u] - startDone), 32'd1);
	endtask

	task automatic writeFrame();
		logic [7:0] a;
		logic [31:0] d;
		logic [55:0] rx;
		int w0;
		int r0;
		a = 8'($urandom);
		d = $urandom;
		w0 = wrPulses;
		r0 = rdPulses;
		cpuFrame({CMD_WRITE, a, d, 8'h00}, 48, 1'b0, rx);
		checks++;
		if (wrPulses != w0 + 1)
			logError("mstWrEn pulses", 32'(wrPulses - w0), 32'd1);
		if (rdPulses != r0)
			logError("mstRdEn pulses on write", 32'(rdPulses - r0), 32'd0);
		if (lastWrAdrs !== {a, 24'h0})
			logError("mstAdrs", lastWrAdrs, {a, 24'h0});
		if (lastWrData !== d)
			logError("mstWrData", lastWrData, d);
		// Monitor sees the pulse one edge after it rises
		if (wrCycle - 1 - lastRiseCycle > 4)
			logError("write latency", 32'(wrCycle - 1 - lastRiseCycle), 32'd4);
	endtask

	task automatic readFrame();
		logic [7:0] a;
		logic [55:0] rx;
		int w0;
		int r0;
		a = 8'($urandom);
		w0 = wrPulses;
		r0 = rdPulses;
		cpuFrame({CMD_READ, a, 8'h00, 32'h0}, 56, 1'b0, rx);
		checks++;
		if (rx[31:0] !== memWord({a, 24'h0}))
			logError("read frame data", rx[31:0], memWord({a, 24'h0}));
		if (rdPulses != r0 + 1)
			logError("mstRdEn pulses", 32'(rdPulses - r0), 32'd1);
		if (wrPulses != w0)
			logError("mstWrEn pulses on read", 32'(wrPulses - w0), 32'd0);
	endtask

	task automatic thruRouting();
		logic [55:0] rx;
		int w0;
		int r0;
		for (int u = 0; u < SFM_NUM; u++)
			busWrite(csrAdrs(unitOffset(u, REG_CTRL)), 32'h0);
		for (int k = 0; k < N_THRU; k++)
		begin
			selM = SFM_SEL_WIDTH'($urandom);
			busWrite(csrAdrs(REG_SEL), 32'(selM));
			spiThru = 1'b1;
			waitCycles(4);
			w0 = wrPulses;
			r0 = rdPulses;
			// Valid command, must not reach the bus
			cpuFrame({(k % 2 == 0) ? CMD_WRITE : CMD_READ, 8'($urandom), $urandom, 8'h00},
				48, 1'b1, rx);
			waitCycles(8);
			if (wrPulses != w0 || rdPulses != r0)
				logError("bus pulses in thru", 32'(wrPulses - w0 + rdPulses - r0), 32'd0);
			spiThru = 1'b0;
			waitCycles(4);
		end
	endtask

	// ------------------
	// Main sequence
	// ------------------
	initial
	begin
		void'($urandom(32'h8173_ec43));
		rstN = 1'b0;
		busAdrs = '0;
		busWrData = '0;
		busWrEn = 1'b0;
		busRdEn = 1'b0;
		mstRdData = '0;
		spiSck = 1'b0;
		spiMosi = 1'b0;
		spiCs = 1'b1;
		spiThru = 1'b0;
		selM = '0;
		ctrlM = '{default: 2'b00};
		divM = '{default: 8'h00};
		repeat (8) @(posedge sClk);
		#10;
		rstN = 1'b1;
		waitCycles(2);
		exerciseRegisters();
		for (int k = 0; k < N_XFER; k++)
			flashTransfer(1'b0);
		for (int k = 0; k < N_BUSY; k++)
			flashTransfer(1'b1);
		for (int k = 0; k < N_FRAME; k++)
			writeFrame();
		for (int k = 0; k < N_FRAME; k++)
			readFrame();
		thruRouting();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule
